// ==== logic/audio_pkg.sv ====
package audio_pkg;

  localparam int unsigned SAMPLE_W    = 16;                 // Codec sample width
  localparam int unsigned COEF_W      = 16;                 // Signed Q1.15 coefficient
  localparam int unsigned ACC_W       = 24;                 // Scaled FIR result width
  localparam int unsigned NUM_TAPS    = 8;                  // Power of two only
  localparam int unsigned TAP_ADDR_W  = $clog2(NUM_TAPS);   // Coefficient index width
  localparam int unsigned BCLK_HALF   = 4;                  // clk_i cycles per bclk half
  localparam int unsigned BITS_PER_CH = 16;                 // Bit clocks per channel word

  typedef logic signed [SAMPLE_W-1:0] sample_t;             // One PCM sample
  typedef logic signed [COEF_W-1:0]   coef_t;               // One filter tap weight

  // Left sits in the upper half, so a frame shifts out left first
  typedef struct packed {
    sample_t left;                                          // Word clock low
    sample_t right;                                         // Word clock high
  } stereo_frame_t;

  typedef struct packed {
    logic                  write;                           // 1 write, 0 read
    logic [TAP_ADDR_W-1:0] addr;                            // Tap index
    coef_t                 wdata;                           // Write data
  } cfg_req_t;

  typedef struct packed {
    coef_t rdata;                                           // Read data, valid with ack
  } cfg_rsp_t;

endpackage

// ==== logic/codec_clock_gen.sv ====
`timescale 1ns/1ps

module codec_clock_gen (
  input  logic clk_i,
  input  logic arst_n_i,
  output logic bclk_o,
  output logic lrclk_o,
  output logic bclk_rise_o,
  output logic bclk_fall_o,
  output logic frame_start_o
);

  logic [$clog2(audio_pkg::BCLK_HALF)-1:0]   div_q;         // Half-period divider
  logic [$clog2(audio_pkg::BITS_PER_CH)-1:0] bit_q;         // Falling edges in current word
  logic                                      bclk_q;
  logic                                      lrclk_q;
  logic                                      half_tick;     // Last cycle of a half period
  logic                                      word_last;     // Last bit of a channel word

  assign half_tick = (div_q == audio_pkg::BCLK_HALF - 1);
  assign word_last = (bit_q == audio_pkg::BITS_PER_CH - 1);

  // Ticks lead the pin edge by one cycle, registered outputs switch on that edge
  assign bclk_rise_o   = half_tick & ~bclk_q;
  assign bclk_fall_o   = half_tick & bclk_q;
  assign frame_start_o = bclk_fall_o & word_last & lrclk_q; // Word clock about to go low

  assign bclk_o  = bclk_q;
  assign lrclk_o = lrclk_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_q   <= '0;
      bclk_q  <= 1'b0;
      lrclk_q <= 1'b1;                                      // Idle high before first frame
      bit_q   <= '1;                                        // First fall opens a left word
    end else begin
      div_q <= half_tick ? '0 : div_q + 1'b1;
      if (half_tick) bclk_q <= ~bclk_q;
      if (bclk_fall_o) begin
        bit_q <= bit_q + 1'b1;                              // Wraps at BITS_PER_CH
        if (word_last) lrclk_q <= ~lrclk_q;                 // Channel switch
      end
    end
  end

  // Word clock pin only moves together with a bit clock pin falling edge
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $changed(lrclk_o) |-> $fell(bclk_o));

endmodule

// ==== logic/serial_audio_rx.sv ====
`timescale 1ns/1ps

module serial_audio_rx (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      adc_sdata_i,
  input  logic                      lrclk_i,
  input  logic                      bclk_rise_i,
  output audio_pkg::stereo_frame_t  frame_o,
  output logic                      rx_valid_o
);

  logic [audio_pkg::SAMPLE_W-1:0]            shift_q;       // MSB first deserializer
  logic [audio_pkg::SAMPLE_W-1:0]            word;          // Shift value incl. current bit
  logic [$clog2(audio_pkg::BITS_PER_CH)-1:0] cnt_q;         // Next bit index
  logic [$clog2(audio_pkg::BITS_PER_CH)-1:0] bit_idx;       // Index of the bit now sampled
  logic                                      lr_q;          // Word clock at previous bit
  logic                                      word_done;
  audio_pkg::stereo_frame_t                  frame_q;
  logic                                      valid_q;

  // A word clock change since the last bit marks an MSB
  assign bit_idx   = (lrclk_i != lr_q) ? '0 : cnt_q;
  assign word      = {shift_q[audio_pkg::SAMPLE_W-2:0], adc_sdata_i};
  assign word_done = bclk_rise_i & (bit_idx == audio_pkg::BITS_PER_CH - 1);

  assign frame_o    = frame_q;
  assign rx_valid_o = valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q   <= '0;
      lr_q    <= 1'b1;                                      // Matches word clock reset level
      valid_q <= 1'b0;
    end else begin
      valid_q <= word_done & lrclk_i;                       // Strobe after right LSB
      if (bclk_rise_i) begin
        cnt_q <= bit_idx + 1'b1;                            // Wraps after LSB
        lr_q  <= lrclk_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bclk_rise_i) shift_q <= word;
    if (word_done) begin
      if (lrclk_i) frame_q.right <= word;
      else         frame_q.left  <= word;
    end
  end

  // One strobe per frame, so never back to back
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rx_valid_o |=> !rx_valid_o);

endmodule

// ==== logic/fir_filter.sv ====
`timescale 1ns/1ps

module fir_filter (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  audio_pkg::stereo_frame_t  frame_i,
  input  logic                      rx_valid_i,
  input  logic                      cfg_req_i,
  input  audio_pkg::cfg_req_t       cfg_i,
  output logic                      cfg_ack_o,
  output audio_pkg::cfg_rsp_t       cfg_rsp_o,
  output audio_pkg::stereo_frame_t  frame_o,
  output logic                      fir_valid_o
);

  typedef enum logic {CFG_IDLE, CFG_ACK} cfg_state_e;

  audio_pkg::coef_t   coef_q [audio_pkg::NUM_TAPS];         // Tap weights
  audio_pkg::sample_t hist_l_q [audio_pkg::NUM_TAPS];       // Index 0 is newest
  audio_pkg::sample_t hist_r_q [audio_pkg::NUM_TAPS];

  cfg_state_e                               cfg_state_q;
  logic                                     cfg_go;         // Access accepted this cycle
  audio_pkg::cfg_rsp_t                      rsp_q;

  logic                                     busy_q;         // MAC sequence running
  logic [audio_pkg::TAP_ADDR_W-1:0]         tap_q;
  logic                                     ch_q;           // 0 left, 1 right
  logic                                     last_tap;
  audio_pkg::sample_t                       samp;           // Multiplier sample operand
  logic signed [audio_pkg::SAMPLE_W+audio_pkg::COEF_W-1:0] prod;
  // Headroom so the top ACC_W bits above the fraction are the exact scaled sum
  logic signed [audio_pkg::ACC_W+audio_pkg::COEF_W-2:0]    acc_q;
  logic signed [audio_pkg::ACC_W+audio_pkg::COEF_W-2:0]    acc_next;
  logic signed [audio_pkg::ACC_W+audio_pkg::COEF_W-2:0]    sum_q;  // Finished channel sum
  logic signed [audio_pkg::ACC_W-1:0]       scaled;         // Sum >>> 15
  logic                                     sum_vld_q;
  logic                                     sum_ch_q;
  audio_pkg::stereo_frame_t                 frame_q;
  logic                                     fir_valid_q;

  // Clamp to sample range when the dropped upper bits are not pure sign
  function automatic audio_pkg::sample_t sat_sample(input logic signed [audio_pkg::ACC_W-1:0] v);
    logic [audio_pkg::ACC_W-audio_pkg::SAMPLE_W:0] top;
    top = v[audio_pkg::ACC_W-1:audio_pkg::SAMPLE_W-1];
    if (&top || ~|top) return v[audio_pkg::SAMPLE_W-1:0];
    else if (v[audio_pkg::ACC_W-1]) return {1'b1, {(audio_pkg::SAMPLE_W-1){1'b0}}};
    else return {1'b0, {(audio_pkg::SAMPLE_W-1){1'b1}}};
  endfunction

  assign last_tap = (tap_q == audio_pkg::NUM_TAPS - 1);
  assign samp     = ch_q ? hist_r_q[tap_q] : hist_l_q[tap_q];
  assign prod     = samp * coef_q[tap_q];                   // Single shared multiplier
  assign acc_next = acc_q + prod;
  assign scaled   = $signed(sum_q[audio_pkg::ACC_W+audio_pkg::COEF_W-2:audio_pkg::COEF_W-1]);

  assign cfg_go      = (cfg_state_q == CFG_IDLE) & cfg_req_i & ~busy_q;  // Deferred while busy
  assign cfg_ack_o   = (cfg_state_q == CFG_ACK);
  assign cfg_rsp_o   = rsp_q;
  assign frame_o     = frame_q;
  assign fir_valid_o = fir_valid_q;

  // Four-phase config slave and coefficient store
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_state_q <= CFG_IDLE;
      for (int i = 0; i < audio_pkg::NUM_TAPS; i++) begin
        coef_q[i] <= (i == 0) ? {1'b0, {(audio_pkg::COEF_W-1){1'b1}}} : '0;  // Pass-through
      end
    end else begin
      case (cfg_state_q)
        CFG_IDLE: if (cfg_go) begin
          cfg_state_q <= CFG_ACK;
          if (cfg_i.write) coef_q[cfg_i.addr] <= cfg_i.wdata;
        end
        CFG_ACK: if (!cfg_req_i) cfg_state_q <= CFG_IDLE;   // Release on req drop
        default: cfg_state_q <= CFG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_go) rsp_q.rdata <= coef_q[cfg_i.addr];          // Held for the ack phase
  end

  // Tap history, cleared so first frames see silence
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < audio_pkg::NUM_TAPS; i++) begin
        hist_l_q[i] <= '0;
        hist_r_q[i] <= '0;
      end
    end else if (rx_valid_i) begin
      hist_l_q[0] <= frame_i.left;
      hist_r_q[0] <= frame_i.right;
      for (int i = 1; i < audio_pkg::NUM_TAPS; i++) begin
        hist_l_q[i] <= hist_l_q[i-1];
        hist_r_q[i] <= hist_r_q[i-1];
      end
    end
  end

  // MAC sequencer, left taps then right taps, then one scaling cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      tap_q       <= '0;
      ch_q        <= 1'b0;
      sum_vld_q   <= 1'b0;
      sum_ch_q    <= 1'b0;
      fir_valid_q <= 1'b0;
    end else begin
      sum_vld_q   <= busy_q & last_tap;
      sum_ch_q    <= ch_q;
      fir_valid_q <= sum_vld_q & sum_ch_q;                  // 18 cycles after rx_valid
      if (rx_valid_i) begin
        busy_q <= 1'b1;
        tap_q  <= '0;
        ch_q   <= 1'b0;
      end else if (busy_q) begin
        tap_q <= tap_q + 1'b1;                              // Wraps into next channel
        if (last_tap) begin
          ch_q <= 1'b1;
          if (ch_q) busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_valid_i) acc_q <= '0;
    else if (busy_q) acc_q <= last_tap ? '0 : acc_next;
    if (busy_q && last_tap) sum_q <= acc_next;
    if (sum_vld_q) begin
      if (sum_ch_q) frame_q.right <= sat_sample(scaled);
      else          frame_q.left  <= sat_sample(scaled);
    end
  end

  // Host holds a request up until it is acknowledged
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(cfg_req_i) |-> cfg_ack_o);

  // Frame rate leaves room for the full MAC sequence
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rx_valid_i |-> !busy_q);

endmodule

// ==== logic/serial_audio_tx.sv ====
`timescale 1ns/1ps

module serial_audio_tx (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  audio_pkg::stereo_frame_t  frame_i,
  input  logic                      fir_valid_i,
  input  logic                      frame_start_i,
  input  logic                      bclk_fall_i,
  output logic                      dac_sdata_o
);

  audio_pkg::stereo_frame_t          latched_q;             // Next frame to play
  logic [2*audio_pkg::SAMPLE_W-1:0]  shift_q;               // Left word in upper half

  assign dac_sdata_o = shift_q[2*audio_pkg::SAMPLE_W-1];    // MSB first

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      latched_q <= '0;                                      // Silence until first result
      shift_q   <= '0;                                      // DAC line low
    end else begin
      if (fir_valid_i) latched_q <= frame_i;
      if (frame_start_i) begin
        shift_q <= latched_q;                               // Left MSB with word clock low
      end else if (bclk_fall_i) begin
        shift_q <= {shift_q[2*audio_pkg::SAMPLE_W-2:0], 1'b0};
      end
    end
  end

  // Frame start is a falling edge tick from the clock generator
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    frame_start_i |-> bclk_fall_i);

  // Filter results land well away from the frame load
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fir_valid_i |-> !frame_start_i);

endmodule

// ==== logic/audio_subsystem.sv ====
`timescale 1ns/1ps

module audio_subsystem (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 adc_sdata_i,
  input  logic                 cfg_req_i,
  input  audio_pkg::cfg_req_t  cfg_i,
  output logic                 bclk_o,
  output logic                 lrclk_o,
  output logic                 dac_sdata_o,
  output logic                 cfg_ack_o,
  output audio_pkg::cfg_rsp_t  cfg_rsp_o
);

  logic                      bclk_rise;                     // Edge ticks from clock gen
  logic                      bclk_fall;
  logic                      frame_start;
  audio_pkg::stereo_frame_t  rx_frame;                      // Deserialized input
  logic                      rx_valid;
  audio_pkg::stereo_frame_t  fir_frame;                     // Filtered output
  logic                      fir_valid;

  codec_clock_gen u_clock_gen (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .bclk_o        (bclk_o),
    .lrclk_o       (lrclk_o),
    .bclk_rise_o   (bclk_rise),
    .bclk_fall_o   (bclk_fall),
    .frame_start_o (frame_start)
  );

  serial_audio_rx u_rx (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .adc_sdata_i (adc_sdata_i),
    .lrclk_i     (lrclk_o),
    .bclk_rise_i (bclk_rise),
    .frame_o     (rx_frame),
    .rx_valid_o  (rx_valid)
  );

  fir_filter u_fir (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .frame_i     (rx_frame),
    .rx_valid_i  (rx_valid),
    .cfg_req_i   (cfg_req_i),
    .cfg_i       (cfg_i),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rsp_o   (cfg_rsp_o),
    .frame_o     (fir_frame),
    .fir_valid_o (fir_valid)
  );

  serial_audio_tx u_tx (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .frame_i       (fir_frame),
    .fir_valid_i   (fir_valid),
    .frame_start_i (frame_start),
    .bclk_fall_i   (bclk_fall),
    .dac_sdata_o   (dac_sdata_o)
  );

endmodule

// ==== sim/tb_audio_model.svh ====
`ifndef TB_AUDIO_MODEL_SVH
`define TB_AUDIO_MODEL_SVH

logic [31:0]              rng_state;                        // Xorshift state
audio_pkg::coef_t         coef_m [audio_pkg::NUM_TAPS];     // Model copy of the taps
audio_pkg::stereo_frame_t sent_q [$];                       // Index is codec frame number
audio_pkg::stereo_frame_t adc_frame;                        // Frame now on the ADC line
audio_pkg::stereo_frame_t cap_frame;                        // DAC frame being assembled
audio_pkg::stereo_frame_t last_cap;                         // Latest complete DAC frame
int unsigned              cap_count;                        // Complete DAC frames seen
logic                     sat_mode;                         // Full scale ADC stimulus
logic                     check_en;                         // Compare DAC frames to model
logic                     bclk_prev;
logic                     adc_lr;                           // Word clock at last ADC bit
logic                     dac_lr;                           // Word clock at last DAC bit
int                       adc_bit;                          // Bit index in ADC word
int                       dac_bit;                          // Bit index in DAC word

function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// Quarter range keeps most sums clear of the clamp
function automatic audio_pkg::coef_t random_coef();
  logic [31:0]      r;
  audio_pkg::coef_t c;
  r = next_rand();
  c = r[15:0];
  return c >>> 2;
endfunction

function automatic audio_pkg::sample_t clamp_sample(input longint v);
  if (v > 32767) return 16'sh7fff;
  if (v < -32768) return 16'sh8000;
  return audio_pkg::sample_t'(v);
endfunction

// Result of ADC frame n is ready only after DAC frame n+1 has loaded
// DAC frame j plays the filter result of ADC frames j-2 down to j-9
function automatic audio_pkg::stereo_frame_t fir_model(input int j);
  longint                   acc_l;
  longint                   acc_r;
  audio_pkg::stereo_frame_t f;
  acc_l = 0;
  acc_r = 0;
  for (int t = 0; t < audio_pkg::NUM_TAPS; t++) begin
    if (j - 2 - t >= 0) begin                               // Older frames are silence
      acc_l += longint'($signed(sent_q[j-2-t].left)) * longint'($signed(coef_m[t]));
      acc_r += longint'($signed(sent_q[j-2-t].right)) * longint'($signed(coef_m[t]));
    end
  end
  f.left  = clamp_sample(acc_l >>> (audio_pkg::COEF_W - 1));
  f.right = clamp_sample(acc_r >>> (audio_pkg::COEF_W - 1));
  return f;
endfunction

task automatic model_reset();
  rng_state = 32'hba8b1172;
  for (int t = 0; t < audio_pkg::NUM_TAPS; t++) begin
    coef_m[t] = (t == 0) ? 16'sh7fff : '0;                  // Pass-through taps
  end
  sent_q.delete();
  cap_count = 0;
  sat_mode  = 1'b0;
  check_en  = 1'b0;
  bclk_prev = 1'b0;
  adc_lr    = 1'b1;                                         // Word clock idles high
  dac_lr    = 1'b1;
  adc_bit   = audio_pkg::SAMPLE_W;                          // No word open yet
  dac_bit   = audio_pkg::SAMPLE_W;
  adc_frame = '0;
  cap_frame = '0;
  last_cap  = '0;
endtask

// Codec side, runs 1 ns after every clock edge
task automatic codec_step();
  logic [31:0] r;
  if (bclk_prev && !bclk) begin                             // Bit clock fell, next ADC bit
    if (lrclk != adc_lr) begin
      adc_bit = 0;
      if (!lrclk) begin                                     // Left word opens a new frame
        r = next_rand();
        adc_frame.left  = sat_mode ? 16'sh7fff : r[31:16];
        adc_frame.right = sat_mode ? 16'sh8000 : r[15:0];
        sent_q.push_back(adc_frame);
      end
    end
    adc_lr = lrclk;
    if (adc_bit < audio_pkg::SAMPLE_W) begin
      adc_sdata = lrclk ? adc_frame.right[audio_pkg::SAMPLE_W-1-adc_bit]
                        : adc_frame.left[audio_pkg::SAMPLE_W-1-adc_bit];
      adc_bit++;
    end
  end
  if (!bclk_prev && bclk) begin                             // Bit clock rose, DAC bit stable
    if (lrclk != dac_lr) dac_bit = 0;
    dac_lr = lrclk;
    if (dac_bit < audio_pkg::SAMPLE_W) begin
      if (lrclk) cap_frame.right[audio_pkg::SAMPLE_W-1-dac_bit] = dac_sdata;
      else       cap_frame.left[audio_pkg::SAMPLE_W-1-dac_bit]  = dac_sdata;
      if (lrclk && dac_bit == audio_pkg::SAMPLE_W - 1) begin // Right LSB closes the frame
        last_cap = cap_frame;
        if (check_en) begin
          compare_frame($sformatf("dac frame %0d", cap_count), fir_model(cap_count),
                        cap_frame);
        end
        cap_count++;
      end
      dac_bit++;
    end
  end
  bclk_prev = bclk;
endtask

`endif

// ==== sim/tb_audio_subsystem.sv ====
`timescale 1ns/1ps

module tb_audio_subsystem;

  logic                 clk;
  logic                 arst_n;
  logic                 adc_sdata;
  logic                 cfg_req;
  audio_pkg::cfg_req_t  cfg;
  logic                 bclk;
  logic                 lrclk;
  logic                 dac_sdata;
  logic                 cfg_ack;
  audio_pkg::cfg_rsp_t  cfg_rsp;
  int unsigned          checks;
  int unsigned          errors;                             // Wrong values
  int unsigned          timeouts;

  `include "tb_audio_model.svh"

  audio_subsystem DUT (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .adc_sdata_i (adc_sdata),
    .cfg_req_i   (cfg_req),
    .cfg_i       (cfg),
    .bclk_o      (bclk),
    .lrclk_o     (lrclk),
    .dac_sdata_o (dac_sdata),
    .cfg_ack_o   (cfg_ack),
    .cfg_rsp_o   (cfg_rsp)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #5 clk = ~clk;                                  // 10 ns period
  end

  initial begin : codec
    forever begin
      @(posedge clk);
      #1;
      codec_step();
    end
  end

  task automatic compare_frame(input string name, input audio_pkg::stereo_frame_t exp,
                               input audio_pkg::stereo_frame_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected L %0d R %0d, actual L %0d R %0d", name,
               $signed(exp.left), $signed(exp.right), $signed(act.left), $signed(act.right));
    end
  endtask

  task automatic compare_coef(input string name, input audio_pkg::coef_t exp,
                              input audio_pkg::coef_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Four-phase access, called 1 ns after a clock edge
  task automatic cfg_access(input logic write, input int addr, input audio_pkg::coef_t wdata,
                            output audio_pkg::coef_t rdata);
    int cycles;
    cfg.write = write;
    cfg.addr  = addr[audio_pkg::TAP_ADDR_W-1:0];
    cfg.wdata = wdata;
    cfg_req   = 1'b1;
    cycles    = 0;
    while (!cfg_ack && cycles < 64) begin                   // Covers a deferred access
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!cfg_ack) begin
      $display("Timeout: no ack for access to tap %0d", addr);
      timeouts++;
    end
    rdata   = cfg_rsp.rdata;                                // Valid while ack is high
    cfg_req = 1'b0;
    cycles  = 0;
    while (cfg_ack && cycles < 64) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cfg_ack) begin
      $display("Timeout: ack stuck high after access to tap %0d", addr);
      timeouts++;
    end
  endtask

  task automatic write_coef(input int addr, input audio_pkg::coef_t value);
    audio_pkg::coef_t unused;
    cfg_access(1'b1, addr, value, unused);
    coef_m[addr] = value;
  endtask

  task automatic check_tap(input int addr);
    audio_pkg::coef_t rd;
    cfg_access(1'b0, addr, '0, rd);
    compare_coef($sformatf("tap %0d readback", addr), coef_m[addr], rd);
  endtask

  task automatic wait_frames(input int unsigned n);
    int unsigned target;
    int unsigned cycles;
    target = cap_count + n;
    cycles = 0;
    while (cap_count < target &&
           cycles < (n + 2) * 4 * audio_pkg::BCLK_HALF * audio_pkg::BITS_PER_CH) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cap_count < target) begin
      $display("Timeout: fewer than %0d DAC frames arrived", n);
      timeouts++;
    end
  endtask

  initial begin : stimulus
    audio_pkg::stereo_frame_t limits;
    arst_n    = 1'b0;
    adc_sdata = 1'b0;
    cfg_req   = 1'b0;
    cfg       = '0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    model_reset();
    limits.left  = 16'sh7fff;
    limits.right = 16'sh8000;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    compare_bit("reset cfg_ack", 1'b0, cfg_ack);            // Idle levels out of reset
    compare_bit("reset dac line", 1'b0, dac_sdata);
    compare_bit("reset word clock", 1'b1, lrclk);
    for (int t = 0; t < audio_pkg::NUM_TAPS; t++) check_tap(t);

    check_en = 1'b1;                                        // Pass-through taps
    wait_frames(10);

    check_en = 1'b0;                                        // Taps in flux
    repeat (12) write_coef(next_rand() % audio_pkg::NUM_TAPS, random_coef());
    for (int t = 0; t < audio_pkg::NUM_TAPS; t++) check_tap(t);
    wait_frames(2);                                         // Let the new taps take hold
    check_en = 1'b1;
    wait_frames(20);

    check_en = 1'b0;
    for (int t = 0; t < audio_pkg::NUM_TAPS; t++) write_coef(t, 16'sh7fff);
    sat_mode = 1'b1;                                        // Left +max, right -max
    wait_frames(10);                                        // History full of full scale
    check_en = 1'b1;
    wait_frames(4);
    compare_frame("saturation limits", limits, last_cap);
    sat_mode = 1'b0;

    // Writes land a few cycles into each accumulation
    check_en = 1'b0;
    for (int t = 0; t < audio_pkg::NUM_TAPS; t++) begin
      wait_frames(1);
      repeat (3) @(posedge clk);
      #1;
      write_coef(t, random_coef());
    end
    wait_frames(2);
    check_en = 1'b1;
    wait_frames(6);

    $display("Checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+sim
logic/audio_pkg.sv
logic/codec_clock_gen.sv
logic/serial_audio_rx.sv
logic/fir_filter.sv
logic/serial_audio_tx.sv
logic/audio_subsystem.sv
sim/tb_audio_subsystem.sv
